/* Makefile */
# Verilator build for the register file execution unit

TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = rf_exec_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the pass or fail result
run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
rtl/rf_pkg.sv
rtl/rf_port_if.sv
rtl/rf_regfile.sv
rtl/rf_alu.sv
rtl/rf_retire_counter.sv
rtl/rf_ctrl_fsm.sv
rtl/rf_exec_top.sv
tb/rf_exec_tb.sv

/* rtl/rf_alu.sv */
//////////////////////////////
// Integer ALU
// Eight register-register operations, combinational
//////////////////////////////

`timescale 1ns/1ps

module rf_alu (
  input  rf_pkg::alu_op_e                   op_i,
  input  logic [rf_pkg::RF_DATA_WIDTH-1:0]  a_i,
  input  logic [rf_pkg::RF_DATA_WIDTH-1:0]  b_i,
  output logic [rf_pkg::RF_DATA_WIDTH-1:0]  result_o
);

  localparam int SHAMT_WIDTH = $clog2(rf_pkg::RF_DATA_WIDTH);

  logic [SHAMT_WIDTH-1:0] shamt;
  logic                   slt;

  // Shift amount is the low bits of rs2 only
  assign shamt = b_i[SHAMT_WIDTH-1:0];

  // Signed compare for SLT
  assign slt = $signed(a_i) < $signed(b_i);

  always_comb begin
    result_o = '0;
    case (op_i)
      rf_pkg::ALU_ADD: begin
        result_o = a_i + b_i;
      end
      rf_pkg::ALU_SUB: begin
        result_o = a_i - b_i;
      end
      rf_pkg::ALU_AND: begin
        result_o = a_i & b_i;
      end
      rf_pkg::ALU_OR: begin
        result_o = a_i | b_i;
      end
      rf_pkg::ALU_XOR: begin
        result_o = a_i ^ b_i;
      end
      // Logical shifts, zeros shifted in
      rf_pkg::ALU_SLL: begin
        result_o = a_i << shamt;
      end
      rf_pkg::ALU_SRL: begin
        result_o = a_i >> shamt;
      end
      // Result is 1 or 0
      rf_pkg::ALU_SLT: begin
        result_o = {{(rf_pkg::RF_DATA_WIDTH-1){1'b0}}, slt};
      end
      // Unknown encodings give zero
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

/* rtl/rf_ctrl_fsm.sv */
//////////////////////////////
// APB slave and operation sequencer
// Decodes host accesses, runs one ALU operation
// per CMD write in IDLE, EXEC, WRITEBACK
//////////////////////////////

`timescale 1ns/1ps

module rf_ctrl_fsm (
  input  logic                                  clk,
  input  logic                                  rst_n,
  // APB slave
  input  logic                                  psel_i,
  input  logic                                  penable_i,
  input  logic                                  pwrite_i,
  input  logic [rf_pkg::APB_ADDR_WIDTH-1:0]     paddr_i,
  input  logic [rf_pkg::RF_DATA_WIDTH-1:0]      pwdata_i,
  output logic [rf_pkg::RF_DATA_WIDTH-1:0]      prdata_o,
  output logic                                  pready_o,
  output logic                                  pslverr_o,
  // Register file
  rf_port_if.ctrl                               rf,
  // ALU
  output rf_pkg::alu_op_e                       alu_op_o,
  output logic [rf_pkg::RF_DATA_WIDTH-1:0]      alu_a_o,
  output logic [rf_pkg::RF_DATA_WIDTH-1:0]      alu_b_o,
  input  logic [rf_pkg::RF_DATA_WIDTH-1:0]      alu_result_i,
  // Retire counter
  output logic                                  retire_o,
  output logic                                  clear_o,
  input  logic [rf_pkg::RETIRE_CNT_WIDTH-1:0]   count_i
);

  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    EXEC      = 2'd1,
    WRITEBACK = 2'd2
  } state_e;

  state_e state_q, state_d;

  logic [rf_pkg::RF_DATA_WIDTH-1:0]  cmd_q;
  logic [rf_pkg::RF_DATA_WIDTH-1:0]  result_q;
  logic [rf_pkg::APB_ADDR_WIDTH-1:0] win_off;
  logic [rf_pkg::RF_ADDR_WIDTH-1:0]  host_idx;
  logic [rf_pkg::RF_ADDR_WIDTH-1:0]  cmd_rd;
  logic [rf_pkg::RF_ADDR_WIDTH-1:0]  cmd_rs1;
  logic [rf_pkg::RF_ADDR_WIDTH-1:0]  cmd_rs2;
  logic aligned, win_hit, cmd_hit, count_hit, addr_err;
  logic done, host_wr;

  //////////////////////////////
  // Address decode
  //////////////////////////////
  assign aligned   = (paddr_i[1:0] == 2'b00);
  assign win_off   = paddr_i - rf_pkg::REG_WIN_BASE;
  // Offset wraps high below the base, so one compare covers both ends
  assign win_hit   = aligned && (win_off < rf_pkg::RF_NUM_REGS * 4);
  assign cmd_hit   = (paddr_i == rf_pkg::CMD_ADDR);
  assign count_hit = (paddr_i == rf_pkg::COUNT_ADDR);
  assign addr_err  = !(win_hit || cmd_hit || count_hit);
  assign host_idx  = win_off[2 +: rf_pkg::RF_ADDR_WIDTH];

  // Command fields from the held command
  assign cmd_rd  = cmd_q[rf_pkg::CMD_RD_LSB  +: rf_pkg::RF_ADDR_WIDTH];
  assign cmd_rs1 = cmd_q[rf_pkg::CMD_RS1_LSB +: rf_pkg::RF_ADDR_WIDTH];
  assign cmd_rs2 = cmd_q[rf_pkg::CMD_RS2_LSB +: rf_pkg::RF_ADDR_WIDTH];

  //////////////////////////////
  // APB handshake
  //////////////////////////////

  // Access phase completes only in IDLE, otherwise wait states
  assign done      = psel_i && penable_i && (state_q == IDLE);
  assign host_wr   = done && pwrite_i;
  assign pready_o  = done;
  assign pslverr_o = done && addr_err;

  // Read data, zero for unmapped addresses
  always_comb begin
    prdata_o = '0;
    if (!pwrite_i) begin
      if (win_hit) begin
        prdata_o = rf.rdata_a;
      end else if (cmd_hit) begin
        prdata_o = cmd_q;
      end else if (count_hit) begin
        prdata_o = {{(rf_pkg::RF_DATA_WIDTH-rf_pkg::RETIRE_CNT_WIDTH){1'b0}}, count_i};
      end
    end
  end

  //////////////////////////////
  // Register file steering
  //////////////////////////////

  // Port A serves the host in IDLE, rs1 during an operation
  assign rf.raddr_a = (state_q == IDLE) ? host_idx : cmd_rs1;
  assign rf.raddr_b = cmd_rs2;

  // Writeback owns the write port, host writes only land in IDLE
  assign rf.we    = (state_q == WRITEBACK) || (host_wr && win_hit);
  assign rf.waddr = (state_q == WRITEBACK) ? cmd_rd : host_idx;
  assign rf.wdata = (state_q == WRITEBACK) ? result_q : pwdata_i;

  // Operands straight from the read ports
  assign alu_a_o  = rf.rdata_a;
  assign alu_b_o  = rf.rdata_b;
  assign alu_op_o = rf_pkg::alu_op_e'(cmd_q[rf_pkg::CMD_OP_LSB +: $bits(rf_pkg::alu_op_e)]);

  // Counter strobes
  assign retire_o = (state_q == WRITEBACK);
  assign clear_o  = host_wr && count_hit;

  //////////////////////////////
  // Sequencer
  //////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (host_wr && cmd_hit) begin
          state_d = EXEC;
        end
      end
      EXEC: begin
        state_d = WRITEBACK;
      end
      WRITEBACK: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cmd_q   <= '0;
    end else begin
      state_q <= state_d;
      // Last command stays readable at CMD
      if (host_wr && cmd_hit) begin
        cmd_q <= pwdata_i;
      end
    end
  end

  // ALU result held for the writeback cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_q <= '0;
    end else if (state_q == EXEC) begin
      result_q <= alu_result_i;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // No transfer completes while an operation is in flight
  a_no_ready_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state_q != IDLE) |-> !pready_o
  );

endmodule

/* rtl/rf_exec_top.sv */
//////////////////////////////
// Register file execution unit, top level
// APB slave, register file, ALU and retire counter
//////////////////////////////

`timescale 1ns/1ps

module rf_exec_top (
  input  logic                               clk,
  input  logic                               rst_n,
  // APB3 slave
  input  logic                               psel_i,
  input  logic                               penable_i,
  input  logic                               pwrite_i,
  input  logic [rf_pkg::APB_ADDR_WIDTH-1:0]  paddr_i,
  input  logic [rf_pkg::RF_DATA_WIDTH-1:0]   pwdata_i,
  output logic [rf_pkg::RF_DATA_WIDTH-1:0]   prdata_o,
  output logic                               pready_o,
  output logic                               pslverr_o
);

  // Controller to ALU
  rf_pkg::alu_op_e                   alu_op;
  logic [rf_pkg::RF_DATA_WIDTH-1:0]  alu_a;
  logic [rf_pkg::RF_DATA_WIDTH-1:0]  alu_b;
  logic [rf_pkg::RF_DATA_WIDTH-1:0]  alu_result;

  // Controller to counter
  logic                                 retire;
  logic                                 clear;
  logic [rf_pkg::RETIRE_CNT_WIDTH-1:0]  count;

  // Register file access, controller to storage
  rf_port_if #(
    .ADDR_WIDTH (rf_pkg::RF_ADDR_WIDTH)
  ) rf_port ();

  rf_ctrl_fsm rf_ctrl_fsm_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .rf           (rf_port.ctrl),
    .alu_op_o     (alu_op),
    .alu_a_o      (alu_a),
    .alu_b_o      (alu_b),
    .alu_result_i (alu_result),
    .retire_o     (retire),
    .clear_o      (clear),
    .count_i      (count)
  );

  rf_regfile #(
    .ADDR_WIDTH (rf_pkg::RF_ADDR_WIDTH)
  ) rf_regfile_i (
    .clk   (clk),
    .rst_n (rst_n),
    .port  (rf_port.store)
  );

  rf_alu rf_alu_i (
    .op_i     (alu_op),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .result_o (alu_result)
  );

  rf_retire_counter rf_retire_counter_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .retire_i (retire),
    .clear_i  (clear),
    .count_o  (count)
  );

endmodule

/* rtl/rf_pkg.sv */
//////////////////////////////
// Register file execution unit
// Shared widths, APB address map, command
// field positions and ALU operation codes
//////////////////////////////

package rf_pkg;

  //////////////////////////////
  // Register file geometry
  //////////////////////////////
  localparam int RF_ADDR_WIDTH = 5;
  localparam int RF_DATA_WIDTH = 32;
  localparam int RF_NUM_REGS   = 2 ** RF_ADDR_WIDTH;

  //////////////////////////////
  // APB address map
  //////////////////////////////
  localparam int APB_ADDR_WIDTH = 8;

  // Register window, one word per register, index in bits 6:2
  localparam logic [APB_ADDR_WIDTH-1:0] REG_WIN_BASE = 8'h00;
  // Command register, writing it starts one operation
  localparam logic [APB_ADDR_WIDTH-1:0] CMD_ADDR     = 8'h80;
  // Retire counter, read for the count, write to clear
  localparam logic [APB_ADDR_WIDTH-1:0] COUNT_ADDR   = 8'h84;

  //////////////////////////////
  // Command word layout
  //////////////////////////////
  localparam int CMD_OP_LSB  = 0;
  localparam int CMD_RD_LSB  = 8;
  localparam int CMD_RS1_LSB = 16;
  localparam int CMD_RS2_LSB = 24;

  // Saturating count of retired operations
  localparam int RETIRE_CNT_WIDTH = 16;

  // Register-register ALU operations
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5,
    ALU_SRL = 3'd6,
    ALU_SLT = 3'd7
  } alu_op_e;

endpackage

/* rtl/rf_port_if.sv */
//////////////////////////////
// Register file access port
// Two read ports and one write port
//////////////////////////////

`timescale 1ns/1ps

interface rf_port_if #(
  parameter int ADDR_WIDTH = rf_pkg::RF_ADDR_WIDTH
);

  // Read port A, host window reads and rs1
  logic [ADDR_WIDTH-1:0]            raddr_a;
  logic [rf_pkg::RF_DATA_WIDTH-1:0] rdata_a;

  // Read port B, rs2 only
  logic [ADDR_WIDTH-1:0]            raddr_b;
  logic [rf_pkg::RF_DATA_WIDTH-1:0] rdata_b;

  // Single write port, shared by host writes and writeback
  logic [ADDR_WIDTH-1:0]            waddr;
  logic [rf_pkg::RF_DATA_WIDTH-1:0] wdata;
  logic                             we;

  // Controller side steers addresses and write data
  modport ctrl (
    output raddr_a, raddr_b, waddr, wdata, we,
    input  rdata_a, rdata_b
  );

  // Storage side returns read data
  modport store (
    input  raddr_a, raddr_b, waddr, wdata, we,
    output rdata_a, rdata_b
  );

endinterface

/* rtl/rf_regfile.sv */
//////////////////////////////
// Flip-flop register file
// Two combinational read ports, one write port,
// x0 hardwired to zero
//////////////////////////////

`timescale 1ns/1ps

module rf_regfile #(
  parameter int ADDR_WIDTH = rf_pkg::RF_ADDR_WIDTH
) (
  input  logic      clk,
  input  logic      rst_n,
  rf_port_if.store  port
);

  localparam int NUM_WORDS = 2 ** ADDR_WIDTH;

  logic [NUM_WORDS-1:0][rf_pkg::RF_DATA_WIDTH-1:0] rf_reg;
  logic [NUM_WORDS-1:0]                            we_dec;

  // One-hot write enable from the write address
  always_comb begin
    for (int i = 0; i < NUM_WORDS; i++) begin
      we_dec[i] = port.we && (port.waddr == ADDR_WIDTH'(i));
    end
  end

  //////////////////////////////
  // Storage
  //////////////////////////////

  // x0 is a constant, no flop behind it
  assign rf_reg[0] = '0;

  // Only the addressed register loads
  for (genvar i = 1; i < NUM_WORDS; i++) begin : g_reg
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        rf_reg[i] <= '0;
      end else if (we_dec[i]) begin
        rf_reg[i] <= port.wdata;
      end
    end
  end

  // Read ports mux the whole array
  assign port.rdata_a = rf_reg[port.raddr_a];
  assign port.rdata_b = rf_reg[port.raddr_b];

  //////////////////////////////
  // Checks
  //////////////////////////////

  // x0 reads zero on both ports, also right after a write to it
  a_x0_zero: assert property (
    @(posedge clk) disable iff (!rst_n)
    ((port.raddr_a == '0) |-> (port.rdata_a == '0)) and
    ((port.raddr_b == '0) |-> (port.rdata_b == '0))
  );

endmodule

/* rtl/rf_retire_counter.sv */
//////////////////////////////
// Retired operation counter
// Saturates at all ones, clear wins over retire
//////////////////////////////

`timescale 1ns/1ps

module rf_retire_counter (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 retire_i,
  input  logic                                 clear_i,
  output logic [rf_pkg::RETIRE_CNT_WIDTH-1:0]  count_o
);

  logic [rf_pkg::RETIRE_CNT_WIDTH-1:0] count_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (clear_i) begin
      count_q <= '0;
    end else if (retire_i && (count_q != '1)) begin
      // Hold at max instead of wrapping
      count_q <= count_q + 1'b1;
    end
  end

  assign count_o = count_q;

  // Only a clear can move the count down
  a_no_decrease: assert property (
    @(posedge clk) disable iff (!rst_n)
    !clear_i |=> (count_q >= $past(count_q))
  );

endmodule

/* tb/rf_exec_tb.sv */
//////////////////////////////
// Testbench for the register file execution unit
// Random APB traffic against a register, command
// and retire count model
//////////////////////////////

`timescale 1ns/1ps

module rf_exec_tb;

  localparam int NUM_TRANS      = 400;
  localparam int TIMEOUT_CYCLES = 50;

  logic                                 clk;
  logic                                 rst_n;
  logic                                 psel_i;
  logic                                 penable_i;
  logic                                 pwrite_i;
  logic [rf_pkg::APB_ADDR_WIDTH-1:0]    paddr_i;
  logic [rf_pkg::RF_DATA_WIDTH-1:0]     pwdata_i;
  logic [rf_pkg::RF_DATA_WIDTH-1:0]     prdata_o;
  logic                                 pready_o;
  logic                                 pslverr_o;

  integer seed;

  // Reference model state
  logic [31:0] model_rf [rf_pkg::RF_NUM_REGS];
  logic [31:0] last_cmd;
  logic [15:0] model_cnt;

  rf_exec_top rf_exec_top_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////
  // Checking and model helpers
  //////////////////////////////

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("FAIL time %0t %s expected %h actual %h", $time, name, exp, act);
      $display("Errors found");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Integer operation as defined for the command register
  function automatic logic [31:0] model_alu(input logic [2:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
    case (op)
      rf_pkg::ALU_ADD: return a + b;
      rf_pkg::ALU_SUB: return a - b;
      rf_pkg::ALU_AND: return a & b;
      rf_pkg::ALU_OR:  return a | b;
      rf_pkg::ALU_XOR: return a ^ b;
      rf_pkg::ALU_SLL: return a << b[4:0];
      rf_pkg::ALU_SRL: return a >> b[4:0];
      default:         return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endcase
  endfunction

  //////////////////////////////
  // APB master
  //////////////////////////////

  // Entered and left 1 ns after a rising edge
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    int waits;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(posedge clk);
    #1;
    penable_i = 1'b1;
    // Sample mid cycle, away from the edges
    #1;
    waits = 0;
    while (!pready_o) begin
      if (waits >= TIMEOUT_CYCLES) begin
        $display("Timeout, pready stayed low for %0d cycles at address %h", waits, addr);
        $display("Errors found");
        $fatal(1, "APB transfer timed out");
      end
      @(posedge clk);
      #2;
      waits++;
    end
    rdata = prdata_o;
    err   = pslverr_o;
    // Completion edge
    @(posedge clk);
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  //////////////////////////////
  // Transactions
  //////////////////////////////

  task automatic win_write(input logic [4:0] idx, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b1, rf_pkg::REG_WIN_BASE + {1'b0, idx, 2'b00}, data, rdata, err);
    check_val("pslverr", 32'd0, {31'd0, err});
    // x0 ignores writes
    if (idx != 5'd0) begin
      model_rf[idx] = data;
    end
  endtask

  task automatic win_read(input logic [4:0] idx);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b0, rf_pkg::REG_WIN_BASE + {1'b0, idx, 2'b00}, $random(seed), rdata, err);
    check_val("pslverr", 32'd0, {31'd0, err});
    check_val("prdata", model_rf[idx], rdata);
  endtask

  // Model result uses the operand values before the write
  task automatic issue_cmd(input logic [31:0] cmd);
    logic [31:0] rdata;
    logic        err;
    logic [4:0]  rd;
    logic [31:0] result;
    rd     = cmd[rf_pkg::CMD_RD_LSB +: 5];
    result = model_alu(cmd[rf_pkg::CMD_OP_LSB +: 3],
                       model_rf[cmd[rf_pkg::CMD_RS1_LSB +: 5]],
                       model_rf[cmd[rf_pkg::CMD_RS2_LSB +: 5]]);
    apb_xfer(1'b1, rf_pkg::CMD_ADDR, cmd, rdata, err);
    check_val("pslverr", 32'd0, {31'd0, err});
    if (rd != 5'd0) begin
      model_rf[rd] = result;
    end
    last_cmd = cmd;
    if (model_cnt != 16'hffff) begin
      model_cnt = model_cnt + 16'd1;
    end
  endtask

  task automatic count_read();
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b0, rf_pkg::COUNT_ADDR, 32'd0, rdata, err);
    check_val("pslverr", 32'd0, {31'd0, err});
    check_val("count", {16'd0, model_cnt}, rdata);
  endtask

  task automatic count_clear();
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b1, rf_pkg::COUNT_ADDR, $random(seed), rdata, err);
    check_val("pslverr", 32'd0, {31'd0, err});
    model_cnt = 16'd0;
  endtask

  task automatic cmd_read();
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b0, rf_pkg::CMD_ADDR, 32'd0, rdata, err);
    check_val("pslverr", 32'd0, {31'd0, err});
    check_val("cmd", last_cmd, rdata);
  endtask

  // Unmapped or misaligned, no effect on the model
  task automatic bad_access();
    logic [7:0]  addr;
    logic        wr;
    logic [31:0] rdata;
    logic        err;
    addr = 8'($random(seed));
    wr   = 1'($random(seed));
    if ((addr[1:0] == 2'b00) &&
        ((addr < 8'h80) || (addr == rf_pkg::CMD_ADDR) || (addr == rf_pkg::COUNT_ADDR))) begin
      addr[0] = 1'b1;
    end
    apb_xfer(wr, addr, $random(seed), rdata, err);
    check_val("pslverr", 32'd1, {31'd0, err});
    if (!wr) begin
      check_val("prdata", 32'd0, rdata);
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial begin
    int          kind;
    logic [31:0] cmd;
    seed      = 32222;
    rst_n     = 1'b0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    last_cmd  = '0;
    model_cnt = '0;
    for (int i = 0; i < rf_pkg::RF_NUM_REGS; i++) begin
      model_rf[i] = '0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    // x0 stays zero after a write
    win_write(5'd0, 32'hffff_ffff);
    win_read(5'd0);
    count_read();

    for (int n = 0; n < NUM_TRANS; n++) begin
      kind = $unsigned($random(seed)) % 10;
      case (kind)
        0, 1, 2: begin
          win_write(5'($random(seed)), $random(seed));
        end
        3, 4: begin
          win_read(5'($random(seed)));
        end
        5, 6: begin
          cmd = $random(seed);
          // Some commands overwrite their own rs1
          if (($random(seed) & 3) == 0) begin
            cmd[rf_pkg::CMD_RD_LSB +: 5] = cmd[rf_pkg::CMD_RS1_LSB +: 5];
          end
          issue_cmd(cmd);
          // Back to back read stalls until writeback is done
          win_read(cmd[rf_pkg::CMD_RD_LSB +: 5]);
        end
        7: begin
          count_read();
        end
        8: begin
          if (1'($random(seed))) begin
            count_clear();
            count_read();
          end else begin
            cmd_read();
          end
        end
        default: begin
          bad_access();
        end
      endcase
    end

    // Final sweep over the whole register file
    for (int i = 0; i < rf_pkg::RF_NUM_REGS; i++) begin
      win_read(5'(i));
    end
    count_read();
    cmd_read();

    $display("No errors");
    $finish;
  end

endmodule
